/* hdl/axi_lite_pkg.sv */
package axi_lite_pkg;

	// Bus widths, fixed for this register block
	localparam int AXI_ADDR_W = 64;
	localparam int AXI_DATA_W = 64;
	localparam int AXI_STRB_W = AXI_DATA_W / 8;
	localparam int WORD_IDX_W = 8;

	// Byte offset bits inside one 64-bit word
	localparam int ADDR_LSB = 3;

	typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
	typedef logic [AXI_DATA_W-1:0] axi_data_t;
	typedef logic [AXI_STRB_W-1:0] axi_strb_t;

	// Register word index, address without byte offset
	typedef logic [WORD_IDX_W-1:0] word_idx_t;

	// AXI response codes
	typedef enum logic [1:0]
	{
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_t;

	// Write request from the slave to the register file
	typedef struct packed
	{
		logic      valid;
		word_idx_t idx;
		axi_data_t data;
		axi_strb_t strb;
	} reg_wr_t;

endpackage

/* hdl/axi4_lite_slave.sv */
`timescale 1ns/1ps

module axi4_lite_slave
	import axi_lite_pkg::*;
(
	input  logic      S_AXI_ACLK,
	input  logic      S_AXI_ARESETN,

	// Write address channel
	input  axi_addr_t S_AXI_AWADDR,
	input  logic [2:0] S_AXI_AWPROT,
	input  logic      S_AXI_AWVALID,
	output logic      S_AXI_AWREADY,

	// Write data channel
	input  axi_data_t S_AXI_WDATA,
	input  axi_strb_t S_AXI_WSTRB,
	input  logic      S_AXI_WVALID,
	output logic      S_AXI_WREADY,

	// Write response channel
	output axi_resp_t S_AXI_BRESP,
	output logic      S_AXI_BVALID,
	input  logic      S_AXI_BREADY,

	// Read address channel
	input  axi_addr_t S_AXI_ARADDR,
	input  logic [2:0] S_AXI_ARPROT,
	input  logic      S_AXI_ARVALID,
	output logic      S_AXI_ARREADY,

	// Read data channel
	output axi_data_t S_AXI_RDATA,
	output axi_resp_t S_AXI_RRESP,
	output logic      S_AXI_RVALID,
	input  logic      S_AXI_RREADY,

	// Register file side
	input  axi_data_t rd_data,
	output reg_wr_t   reg_wr,
	output word_idx_t rd_idx
);

	// Handshake flags
	logic awready_q;
	logic wready_q;
	logic aw_en_q;
	logic bvalid_q;
	logic arready_q;
	logic rvalid_q;

	// Set and clear terms of each flag
	logic awready_set;
	logic awready_rst;
	logic wready_set;
	logic wready_rst;
	logic aw_en_set;
	logic aw_en_rst;
	logic bvalid_set;
	logic bvalid_rst;
	logic arready_set;
	logic arready_rst;
	logic rvalid_set;
	logic rvalid_rst;

	logic wr_fire;
	logic rd_fire;

	// Captured word indices and read data
	word_idx_t aw_idx_q;
	word_idx_t ar_idx_q;
	axi_data_t rdata_q;

	// Set wins over clear, otherwise hold
	function automatic logic sr_next(input logic q, input logic set, input logic rst);
		if (set)
		begin
			return 1'b1;
		end
		else if (rst)
		begin
			return 1'b0;
		end
		return q;
	endfunction

	// Write accept needs both channels and no response in flight
	assign awready_set = ~awready_q & S_AXI_AWVALID & S_AXI_WVALID & aw_en_q;
	assign awready_rst = awready_q;
	assign wready_set  = ~wready_q & S_AXI_WVALID & S_AXI_AWVALID & aw_en_q;
	assign wready_rst  = wready_q;

	// Write enable is released once the B handshake completes
	assign aw_en_set = bvalid_q & S_AXI_BREADY;
	assign aw_en_rst = awready_set;

	assign wr_fire = awready_q & S_AXI_AWVALID & wready_q & S_AXI_WVALID;

	assign bvalid_set = wr_fire & ~bvalid_q;
	assign bvalid_rst = bvalid_q & S_AXI_BREADY;

	// No new read address while a read response waits
	assign arready_set = ~arready_q & S_AXI_ARVALID & ~rvalid_q;
	assign arready_rst = arready_q;

	assign rd_fire = arready_q & S_AXI_ARVALID & ~rvalid_q;

	assign rvalid_set = rd_fire;
	assign rvalid_rst = rvalid_q & S_AXI_RREADY;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			awready_q <= 1'b0;
			wready_q  <= 1'b0;
			aw_en_q   <= 1'b1;
			bvalid_q  <= 1'b0;
			arready_q <= 1'b0;
			rvalid_q  <= 1'b0;
		end
		else
		begin
			awready_q <= sr_next(awready_q, awready_set, awready_rst);
			wready_q  <= sr_next(wready_q, wready_set, wready_rst);
			aw_en_q   <= sr_next(aw_en_q, aw_en_set, aw_en_rst);
			bvalid_q  <= sr_next(bvalid_q, bvalid_set, bvalid_rst);
			arready_q <= sr_next(arready_q, arready_set, arready_rst);
			rvalid_q  <= sr_next(rvalid_q, rvalid_set, rvalid_rst);
		end
	end

	// Address capture, byte offset dropped
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (awready_set)
		begin
			aw_idx_q <= word_idx_t'(S_AXI_AWADDR >> ADDR_LSB);
		end
		if (arready_set)
		begin
			ar_idx_q <= word_idx_t'(S_AXI_ARADDR >> ADDR_LSB);
		end
	end

	// Read data is registered in the accept cycle and held with RVALID
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			rdata_q <= '0;
		end
		else if (rd_fire)
		begin
			rdata_q <= rd_data;
		end
	end

	// Write request to the register file, live for the accept cycle only
	always_comb
	begin
		reg_wr.valid = wr_fire;
		reg_wr.idx   = aw_idx_q;
		reg_wr.data  = S_AXI_WDATA;
		reg_wr.strb  = S_AXI_WSTRB;
	end

	assign rd_idx = ar_idx_q;

	assign S_AXI_AWREADY = awready_q;
	assign S_AXI_WREADY  = wready_q;
	assign S_AXI_BVALID  = bvalid_q;
	assign S_AXI_BRESP   = OKAY;

	assign S_AXI_ARREADY = arready_q;
	assign S_AXI_RVALID  = rvalid_q;
	assign S_AXI_RDATA   = rdata_q;
	assign S_AXI_RRESP   = OKAY;

	// AWPROT and ARPROT have no meaning for this block

endmodule

/* hdl/slv_regs.sv */
`timescale 1ns/1ps

module slv_regs
	import axi_lite_pkg::*;
#(
	parameter int REG_COUNT = 4
)
(
	input  logic      S_AXI_ACLK,
	input  logic      S_AXI_ARESETN,
	input  reg_wr_t   reg_wr,
	input  word_idx_t rd_idx,
	output axi_data_t rd_data
);

	// Index bits that select a register
	localparam int SEL_W = (REG_COUNT > 1) ? $clog2(REG_COUNT) : 1;

	axi_data_t regs [REG_COUNT];

	logic [SEL_W-1:0] wr_sel;
	logic [SEL_W-1:0] rd_sel;
	logic             wr_hit;
	logic             rd_hit;
	axi_data_t        wr_mask;

	// Expand byte strobes to a bit mask
	function automatic axi_data_t strb_to_mask(input axi_strb_t strb);
		axi_data_t mask;
		mask = '0;
		for (int b = 0; b < AXI_STRB_W; b++)
		begin
			if (strb[b])
			begin
				mask[b*8 +: 8] = 8'hff;
			end
		end
		return mask;
	endfunction

	// Indices at or above REG_COUNT hit nothing
	assign wr_hit = reg_wr.valid && (int'(reg_wr.idx) < REG_COUNT);
	assign rd_hit = int'(rd_idx) < REG_COUNT;

	assign wr_sel  = reg_wr.idx[SEL_W-1:0];
	assign rd_sel  = rd_idx[SEL_W-1:0];
	assign wr_mask = strb_to_mask(reg_wr.strb);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			for (int r = 0; r < REG_COUNT; r++)
			begin
				regs[r] <= '0;
			end
		end
		else if (wr_hit)
		begin
			// Byte merge, unstrobed bytes keep their value
			regs[wr_sel] <= (regs[wr_sel] & ~wr_mask) | (reg_wr.data & wr_mask);
		end
	end

	// Combinational read decode
	always_comb
	begin
		if (rd_hit)
		begin
			rd_data = regs[rd_sel];
		end
		else
		begin
			rd_data = '0;
		end
	end

endmodule

/* hdl/axi_lite_reg_top.sv */
`timescale 1ns/1ps

module axi_lite_reg_top
	import axi_lite_pkg::*;
#(
	parameter int REG_COUNT = 4
)
(
	input  logic      S_AXI_ACLK,
	input  logic      S_AXI_ARESETN,

	input  axi_addr_t S_AXI_AWADDR,
	input  logic [2:0] S_AXI_AWPROT,
	input  logic      S_AXI_AWVALID,
	output logic      S_AXI_AWREADY,

	input  axi_data_t S_AXI_WDATA,
	input  axi_strb_t S_AXI_WSTRB,
	input  logic      S_AXI_WVALID,
	output logic      S_AXI_WREADY,

	output axi_resp_t S_AXI_BRESP,
	output logic      S_AXI_BVALID,
	input  logic      S_AXI_BREADY,

	input  axi_addr_t S_AXI_ARADDR,
	input  logic [2:0] S_AXI_ARPROT,
	input  logic      S_AXI_ARVALID,
	output logic      S_AXI_ARREADY,

	output axi_data_t S_AXI_RDATA,
	output axi_resp_t S_AXI_RRESP,
	output logic      S_AXI_RVALID,
	input  logic      S_AXI_RREADY
);

	// Slave to register file
	reg_wr_t   reg_wr;
	word_idx_t rd_idx;
	axi_data_t rd_data;

	axi4_lite_slave u_slave
	(
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.S_AXI_AWADDR  (S_AXI_AWADDR),
		.S_AXI_AWPROT  (S_AXI_AWPROT),
		.S_AXI_AWVALID (S_AXI_AWVALID),
		.S_AXI_AWREADY (S_AXI_AWREADY),
		.S_AXI_WDATA   (S_AXI_WDATA),
		.S_AXI_WSTRB   (S_AXI_WSTRB),
		.S_AXI_WVALID  (S_AXI_WVALID),
		.S_AXI_WREADY  (S_AXI_WREADY),
		.S_AXI_BRESP   (S_AXI_BRESP),
		.S_AXI_BVALID  (S_AXI_BVALID),
		.S_AXI_BREADY  (S_AXI_BREADY),
		.S_AXI_ARADDR  (S_AXI_ARADDR),
		.S_AXI_ARPROT  (S_AXI_ARPROT),
		.S_AXI_ARVALID (S_AXI_ARVALID),
		.S_AXI_ARREADY (S_AXI_ARREADY),
		.S_AXI_RDATA   (S_AXI_RDATA),
		.S_AXI_RRESP   (S_AXI_RRESP),
		.S_AXI_RVALID  (S_AXI_RVALID),
		.S_AXI_RREADY  (S_AXI_RREADY),
		.rd_data       (rd_data),
		.reg_wr        (reg_wr),
		.rd_idx        (rd_idx)
	);

	slv_regs #(
		.REG_COUNT (REG_COUNT)
	) u_regs
	(
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.reg_wr        (reg_wr),
		.rd_idx        (rd_idx),
		.rd_data       (rd_data)
	);

endmodule

/* testbench/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen
#(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 2
)
(
	output logic S_AXI_ACLK,
	output logic S_AXI_ARESETN
);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #(PERIOD_NS / 2) S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// Reset held over the first rising edges, released on a falling edge
	initial
	begin
		S_AXI_ARESETN = 1'b0;
		repeat (RESET_CYCLES) @(posedge S_AXI_ACLK);
		@(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;
	end

endmodule

/* testbench/axi_lite_reg_assert.sv */
`timescale 1ns/1ps

module axi_lite_reg_assert
	import axi_lite_pkg::*;
(
	input logic      S_AXI_ACLK,
	input logic      S_AXI_ARESETN,
	input logic      S_AXI_AWREADY,
	input logic      S_AXI_WREADY,
	input logic      S_AXI_BVALID,
	input logic      S_AXI_BREADY,
	input logic      S_AXI_ARREADY,
	input logic      S_AXI_RVALID,
	input logic      S_AXI_RREADY,
	input axi_data_t S_AXI_RDATA
);

	// Count of failed assertions
	int assert_errors = 0;

	// Responses hold until taken
	bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID)
		else
		begin
			$error("BVALID dropped before BREADY was seen");
			assert_errors++;
		end

	rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(S_AXI_RDATA))
		else
		begin
			$error("RVALID or RDATA changed before RREADY was seen");
			assert_errors++;
		end

	// Address and data accepted together
	aw_w_ready_equal: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_AWREADY == S_AXI_WREADY)
		else
		begin
			$error("AWREADY and WREADY differ");
			assert_errors++;
		end

	awready_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_AWREADY |=> !S_AXI_AWREADY)
		else
		begin
			$error("AWREADY high for more than one cycle");
			assert_errors++;
		end

	arready_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_ARREADY |=> !S_AXI_ARREADY)
		else
		begin
			$error("ARREADY high for more than one cycle");
			assert_errors++;
		end

	// No read accept while a response is pending
	arready_blocked: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_RVALID |=> !$rose(S_AXI_ARREADY))
		else
		begin
			$error("ARREADY rose while RVALID was high");
			assert_errors++;
		end

endmodule

/* testbench/tb_axi_lite_reg_top.sv */
`timescale 1ns/1ps

module tb_axi_lite_reg_top
	import axi_lite_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 50;
	localparam string INPUT_FILE = "testbench/axi_lite_input.txt";

	typedef enum int {WAIT_RESET, WAIT_AWREADY, WAIT_BVALID, WAIT_ARREADY, WAIT_RVALID} wait_sel_t;

	logic      S_AXI_ACLK;
	logic      S_AXI_ARESETN;
	axi_addr_t S_AXI_AWADDR;
	logic [2:0] S_AXI_AWPROT;
	logic      S_AXI_AWVALID;
	logic      S_AXI_AWREADY;
	axi_data_t S_AXI_WDATA;
	axi_strb_t S_AXI_WSTRB;
	logic      S_AXI_WVALID;
	logic      S_AXI_WREADY;
	axi_resp_t S_AXI_BRESP;
	logic      S_AXI_BVALID;
	logic      S_AXI_BREADY;
	axi_addr_t S_AXI_ARADDR;
	logic [2:0] S_AXI_ARPROT;
	logic      S_AXI_ARVALID;
	logic      S_AXI_ARREADY;
	axi_data_t S_AXI_RDATA;
	axi_resp_t S_AXI_RRESP;
	logic      S_AXI_RVALID;
	logic      S_AXI_RREADY;

	int mismatch_errors = 0;
	int timeout_errors = 0;
	int file_errors = 0;
	logic [7:0] lfsr = 8'd49;

	tb_clk_gen u_clk (.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN));

	axi_lite_reg_top uut (.*);

	bind axi4_lite_slave axi_lite_reg_assert u_assert (.*);

	// Fibonacci LFSR, taps 8 6 5 4
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	task automatic next_stall(output int n);
		n = 0;
		for (int i = 0; i < 2; i++)
		begin
			lfsr = lfsr_next(lfsr);
			n = (n << 1) | int'(lfsr[0]);
		end
	endtask

	function automatic logic probe(input wait_sel_t sel);
		case (sel)
			WAIT_RESET:   return S_AXI_ARESETN;
			WAIT_AWREADY: return S_AXI_AWREADY;
			WAIT_BVALID:  return S_AXI_BVALID;
			WAIT_ARREADY: return S_AXI_ARREADY;
			WAIT_RVALID:  return S_AXI_RVALID;
			default:      return 1'b0;
		endcase
	endfunction

	// Checked on falling edges, where DUT outputs are settled
	task automatic wait_high(input wait_sel_t sel, input string what, output bit ok);
		int cycles;
		cycles = 0;
		ok = probe(sel);
		while (!ok && cycles < TIMEOUT_CYCLES)
		begin
			@(negedge S_AXI_ACLK);
			cycles++;
			ok = probe(sel);
		end
		if (!ok)
		begin
			timeout_errors++;
			$display("Timeout at %0t: %s did not happen within %0d cycles",
				$time, what, TIMEOUT_CYCLES);
		end
	endtask

	task automatic report_mismatch(input string name, input axi_data_t exp, input axi_data_t act);
		mismatch_errors++;
		$display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
	endtask

	task automatic check_rdata(input axi_data_t expected);
		if (S_AXI_RDATA !== expected)
			report_mismatch("S_AXI_RDATA", expected, S_AXI_RDATA);
		if (S_AXI_RRESP !== OKAY)
			report_mismatch("S_AXI_RRESP", 64'(OKAY), 64'(S_AXI_RRESP));
	endtask

	task automatic do_write(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb);
		bit ok;
		int stall;
		S_AXI_AWADDR = addr;
		S_AXI_WDATA = data;
		S_AXI_WSTRB = strb;
		S_AXI_AWVALID = 1'b1;
		S_AXI_WVALID = 1'b1;
		wait_high(WAIT_AWREADY, "write address handshake (AWREADY)", ok);
		if (!ok)
			return;
		if (S_AXI_WREADY !== 1'b1)
			report_mismatch("S_AXI_WREADY", 64'd1, 64'(S_AXI_WREADY));
		// Transfer completes on the coming rising edge
		@(negedge S_AXI_ACLK);
		S_AXI_AWVALID = 1'b0;
		S_AXI_WVALID = 1'b0;
		next_stall(stall);
		repeat (stall) @(negedge S_AXI_ACLK);
		S_AXI_BREADY = 1'b1;
		wait_high(WAIT_BVALID, "write response handshake (BVALID)", ok);
		if (!ok)
			return;
		if (S_AXI_BRESP !== OKAY)
			report_mismatch("S_AXI_BRESP", 64'(OKAY), 64'(S_AXI_BRESP));
		@(negedge S_AXI_ACLK);
		S_AXI_BREADY = 1'b0;
	endtask

	task automatic do_read(input axi_addr_t addr, input axi_data_t expected);
		bit ok;
		int stall;
		S_AXI_ARADDR = addr;
		S_AXI_ARVALID = 1'b1;
		wait_high(WAIT_ARREADY, "read address handshake (ARREADY)", ok);
		if (!ok)
			return;
		// ARVALID stays high as a second read of the same address,
		// which may only be accepted once the first response is taken
		@(negedge S_AXI_ACLK);
		next_stall(stall);
		repeat (stall) @(negedge S_AXI_ACLK);
		S_AXI_RREADY = 1'b1;
		wait_high(WAIT_RVALID, "read data handshake (RVALID)", ok);
		if (!ok)
			return;
		check_rdata(expected);
		@(negedge S_AXI_ACLK);
		wait_high(WAIT_ARREADY, "second read address handshake (ARREADY)", ok);
		if (!ok)
			return;
		@(negedge S_AXI_ACLK);
		S_AXI_ARVALID = 1'b0;
		wait_high(WAIT_RVALID, "second read data handshake (RVALID)", ok);
		if (!ok)
			return;
		check_rdata(expected);
		@(negedge S_AXI_ACLK);
		S_AXI_RREADY = 1'b0;
	endtask

	initial
	begin
		int fd;
		int fields;
		int txn_count;
		int assert_errors;
		string line;
		logic [7:0] op;
		axi_addr_t addr;
		axi_data_t data;
		axi_strb_t strb;
		axi_data_t expected;
		bit ok;
		S_AXI_AWADDR = '0;
		S_AXI_AWPROT = '0;
		S_AXI_AWVALID = 1'b0;
		S_AXI_WDATA = '0;
		S_AXI_WSTRB = '0;
		S_AXI_WVALID = 1'b0;
		S_AXI_BREADY = 1'b0;
		S_AXI_ARADDR = '0;
		S_AXI_ARPROT = '0;
		S_AXI_ARVALID = 1'b0;
		S_AXI_RREADY = 1'b0;
		txn_count = 0;
		fd = $fopen(INPUT_FILE, "r");
		if (fd == 0)
		begin
			file_errors++;
			$display("Could not open the stimulus file %s", INPUT_FILE);
		end
		else
		begin
			wait_high(WAIT_RESET, "reset release", ok);
			@(negedge S_AXI_ACLK);
			// Lines other than W or R records are comments
			while (ok && timeout_errors == 0 && $fgets(line, fd) != 0)
			begin
				fields = $sscanf(line, "%c %h %h %h %h", op, addr, data, strb, expected);
				if (fields == 5 && op == "W")
				begin
					do_write(addr, data, strb);
					txn_count++;
				end
				else if (fields == 5 && op == "R")
				begin
					do_read(addr, expected);
					txn_count++;
				end
			end
			$fclose(fd);
			if (txn_count == 0)
			begin
				file_errors++;
				$display("The stimulus file held no transactions");
			end
		end
		assert_errors = uut.u_slave.u_assert.assert_errors;
		$display("Errors: %0d mismatch, %0d timeout, %0d file, %0d assertion",
			mismatch_errors, timeout_errors, file_errors, assert_errors);
		if (mismatch_errors + timeout_errors + file_errors + assert_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* testbench/axi_lite_input.txt */
# op addr data strb expected, all hex; op W is a write, R a read
# expected is the read data and is 0 on write lines
R 00 0000000000000000 00 0000000000000000
R 08 0000000000000000 00 0000000000000000
R 10 0000000000000000 00 0000000000000000
R 18 0000000000000000 00 0000000000000000
W 00 0123456789abcdef ff 0000000000000000
W 08 fedcba9876543210 ff 0000000000000000
W 10 a5a5a5a5a5a5a5a5 ff 0000000000000000
W 18 0f0f0f0f0f0f0f0f ff 0000000000000000
R 00 0000000000000000 00 0123456789abcdef
R 08 0000000000000000 00 fedcba9876543210
R 10 0000000000000000 00 a5a5a5a5a5a5a5a5
R 18 0000000000000000 00 0f0f0f0f0f0f0f0f
W 00 ffffffffffffffff 01 0000000000000000
W 08 1122334455667788 f0 0000000000000000
W 10 0000000000000000 3c 0000000000000000
W 18 deadbeefcafef00d 81 0000000000000000
W 18 ffffffffffffffff 00 0000000000000000
R 00 0000000000000000 00 0123456789abcdff
R 08 0000000000000000 00 1122334476543210
R 10 0000000000000000 00 a5a500000000a5a5
R 18 0000000000000000 00 de0f0f0f0f0f0f0d
W 20 1111111111111111 ff 0000000000000000
R 20 0000000000000000 00 0000000000000000
R 00 0000000000000000 00 0123456789abcdff
R 08 0000000000000000 00 1122334476543210
R 10 0000000000000000 00 a5a500000000a5a5
R 18 0000000000000000 00 de0f0f0f0f0f0f0d
W 08 0badc0de12345678 ff 0000000000000000
R 08 0000000000000000 00 0badc0de12345678
R 0f 0000000000000000 00 0badc0de12345678

/* flist.f */
hdl/axi_lite_pkg.sv
hdl/axi4_lite_slave.sv
hdl/slv_regs.sv
hdl/axi_lite_reg_top.sv
testbench/tb_clk_gen.sv
testbench/axi_lite_reg_assert.sv
testbench/tb_axi_lite_reg_top.sv
